/* filelist.f */
+incdir+src
src/uart_pkg.sv
src/uart_ctrl.sv
src/baud_timer.sv
src/uart_tx_shift.sv
src/uart_rx_shift.sv
src/uart_top.sv
verif/uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f --top-module uart_tb -o uart_tb_sim

./obj_dir/uart_tb_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

/* verif/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_tb;

  localparam int CLKS   = `UART_CLKS_PER_BIT;
  localparam int FBITS  = `UART_FRAME_BITS;
  localparam int FRAMES = 25;
  localparam int CYCLE_LIMIT = FRAMES * FBITS * CLKS * 2 + 500;

  logic                          clk;
  logic                          rst_n;
  logic [`UART_CMD_WIDTH-1:0]    cmd_in;
  logic                          cmd_vld;
  logic                          rx_drv;
  logic                          loopback;
  logic                          rx_line;
  logic                          tx;
  logic                          cmd_rdy;
  logic                          read_rdy;
  logic [uart_pkg::READ_WIDTH:0] read_data;

  logic [uart_pkg::READ_WIDTH:0] rd_q [$];
  int                            errors;
  int                            tests_failed;
  int                            cycle_cnt;
  int unsigned                   seed_val;

  // rx comes either from the DUT's own tx or from the frame driver.
  assign rx_line = loopback ? tx : rx_drv;

  uart_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx_line),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: no finish after %0d clock cycles, run stopped", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // every read strobe is kept, so a lost or extra result shows in the count.
  always @(negedge clk) begin
    if (rst_n && read_rdy === 1'b1) begin
      rd_q.push_back(read_data);
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("ERROR @%0t: %s: got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  function automatic logic odd_parity(input logic [7:0] b);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        n++;
      end
    end
    return (n % 2 == 0) ? 1'b1 : 1'b0;
  endfunction

  // called on a falling edge; returns once the command has been taken.
  task automatic send_cmd(input logic [`UART_CMD_WIDTH-1:0] word);
    cmd_in  = word;
    cmd_vld = 1'b1;
    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_tx_start(output int idle);
    idle = 0;
    while (tx !== 1'b0) begin
      idle++;
      @(negedge clk);
    end
  endtask

  // one sample per cycle, the mid-bit one is the decoded value.
  task automatic capture_frame(output logic [FBITS-1:0] frame, output int glitches);
    logic [CLKS-1:0] s;
    frame    = '0;
    glitches = 0;
    for (int k = 0; k < FBITS; k++) begin
      for (int c = 0; c < CLKS; c++) begin
        s[c] = tx;
        @(negedge clk);
      end
      frame[k] = s[CLKS/2];
      for (int c = 0; c < CLKS; c++) begin
        if (s[c] !== frame[k]) begin
          glitches++;
        end
      end
    end
  endtask

  task automatic check_frame(input logic [FBITS-1:0] frame, input int glitches,
                             input logic [7:0] exp_byte);
    check(32'(frame[0]), 0, "start bit");
    check(32'(frame[8:1]), 32'(exp_byte), "frame data");
    check(32'(frame[9]), 32'(odd_parity(exp_byte)), "parity bit");
    check(32'(frame[10]), 1, "stop bit");
    check(32'(glitches), 0, "cycles off the bit value");
  endtask

  task automatic drive_rx_frame(input logic [7:0] b, input logic bad_par,
                                input logic bad_stop);
    logic [FBITS-1:0] frame;
    frame = {~bad_stop, odd_parity(b) ^ bad_par, b, 1'b0};
    for (int k = 0; k < FBITS; k++) begin
      rx_drv = frame[k];
      repeat (CLKS) @(negedge clk);
    end
    rx_drv = 1'b1;
  endtask

  task automatic receive_one(input logic [7:0] b, input logic bad_par,
                             input logic bad_stop, input logic exp_err);
    rd_q.delete();
    drive_rx_frame(b, bad_par, bad_stop);
    while (rd_q.size() == 0) begin
      @(negedge clk);
    end
    repeat (2 * CLKS) @(negedge clk);
    check(32'(rd_q.size()), 1, "read strobes per frame");
    check(32'(rd_q[0]), 32'({exp_err, b}), "read result");
  endtask

  task automatic reset_state_test();
    int e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      check(32'(tx), 1, "tx idle after reset");
      check(32'(cmd_rdy), 1, "cmd_rdy after reset");
      check(32'(read_rdy), 0, "read_rdy after reset");
      check(32'(read_data), 0, "read_data after reset");
      @(negedge clk);
    end
    report_test("reset_state", e0);
  endtask

  task automatic serialise_test();
    int               e0;
    int               idle;
    int               glitches;
    logic [FBITS-1:0] frame;
    e0 = errors;
    send_cmd(16'hA53C);
    wait_tx_start(idle);
    check(32'(idle), 2, "cycles from accept to start bit");
    capture_frame(frame, glitches);
    check_frame(frame, glitches, 8'hA5);
    wait_tx_start(idle);
    check(32'(idle), 2, "idle cycles between frames");
    capture_frame(frame, glitches);
    check_frame(frame, glitches, 8'h3C);
    report_test("serialise", e0);
  endtask

  task automatic handshake_test();
    int               e0;
    int               idle;
    int               glitches;
    int               low_cnt;
    int               extra;
    logic [FBITS-1:0] frame;
    logic [7:0]       exp_bytes [4];
    e0 = errors;
    exp_bytes = '{8'h12, 8'h34, 8'hC0, 8'hDE};
    send_cmd(16'h1234);
    check(32'(cmd_rdy), 0, "cmd_rdy in the cycle after accept");
    // second command waits on the handshake the whole time.
    cmd_in  = 16'hC0DE;
    cmd_vld = 1'b1;
    fork
      begin
        for (int f = 0; f < 4; f++) begin
          wait_tx_start(idle);
          capture_frame(frame, glitches);
          check_frame(frame, glitches, exp_bytes[f]);
        end
      end
      begin
        low_cnt = 0;
        while (cmd_rdy !== 1'b1) begin
          low_cnt++;
          @(negedge clk);
        end
        check(32'(low_cnt), 32'(4 + 2 * FBITS * CLKS), "cycles with cmd_rdy low");
        @(negedge clk);
        check(32'(cmd_rdy), 0, "held command taken at once");
        cmd_vld = 1'b0;
      end
    join
    extra = 0;
    repeat (2 * FBITS * CLKS) begin
      if (tx !== 1'b1) begin
        extra++;
      end
      @(negedge clk);
    end
    check(32'(extra), 0, "line activity after the second command");
    check(32'(cmd_rdy), 1, "cmd_rdy back after both commands");
    report_test("handshake", e0);
  endtask

  task automatic good_receive_test();
    int e0;
    e0 = errors;
    loopback = 1'b0;
    receive_one(8'h96, 1'b0, 1'b0, 1'b0);
    report_test("good_receive", e0);
  endtask

  task automatic faulty_receive_test();
    int e0;
    e0 = errors;
    loopback = 1'b0;
    receive_one(8'h5A, 1'b1, 1'b0, 1'b1);
    repeat (2 * CLKS) @(negedge clk);
    receive_one(8'hC3, 1'b0, 1'b1, 1'b1);
    repeat (2 * CLKS) @(negedge clk);
    report_test("faulty_receive", e0);
  endtask

  task automatic loopback_test();
    int                         e0;
    logic [`UART_CMD_WIDTH-1:0] word;
    e0 = errors;
    loopback = 1'b1;
    for (int i = 0; i < 8; i++) begin
      word = 16'($urandom);
      rd_q.delete();
      send_cmd(word);
      while (rd_q.size() < 2) begin
        @(negedge clk);
      end
      while (cmd_rdy !== 1'b1) begin
        @(negedge clk);
      end
      repeat (2 * CLKS) @(negedge clk);
      check(32'(rd_q.size()), 2, "read results per command");
      if (rd_q.size() == 2) begin
        check(32'(rd_q[0]), 32'({1'b0, word[15:8]}), "loopback high byte");
        check(32'(rd_q[1]), 32'({1'b0, word[7:0]}), "loopback low byte");
      end
    end
    loopback = 1'b0;
    report_test("loopback", e0);
  endtask

  initial begin
    seed_val     = $urandom(3);
    errors       = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    rx_drv       = 1'b1;
    loopback     = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    serialise_test();
    handshake_test();
    good_receive_test();
    faulty_receive_test();
    loopback_test();

    $display("tests run 6, failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_top (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic [`UART_CMD_WIDTH-1:0] cmd_in,
  input  wire logic                       cmd_vld,
  input  wire logic                       rx,
  output logic                            tx,
  output logic                            cmd_rdy,
  output logic                            read_rdy,
  output logic [uart_pkg::READ_WIDTH:0]   read_data
);

  logic       frame_start;
  logic [7:0] frame_byte;
  logic       frame_done;
  logic       tx_timer_run;
  logic       tx_bit_tick;
  logic       rx_timer_run;
  logic       rx_mid_tick;

  uart_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .frame_done  (frame_done),
    .cmd_rdy     (cmd_rdy),
    .frame_start (frame_start),
    .frame_byte  (frame_byte)
  );

  // transmit side only needs the end of each bit.
  baud_timer tx_timer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .timer_run (tx_timer_run),
    .bit_tick  (tx_bit_tick),
    .mid_tick  ()
  );

  uart_tx_shift tx_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .frame_byte  (frame_byte),
    .bit_tick    (tx_bit_tick),
    .timer_run   (tx_timer_run),
    .frame_done  (frame_done),
    .tx          (tx)
  );

  // receive side samples at mid-bit only.
  baud_timer rx_timer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .timer_run (rx_timer_run),
    .bit_tick  (),
    .mid_tick  (rx_mid_tick)
  );

  uart_rx_shift rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .mid_tick  (rx_mid_tick),
    .timer_run (rx_timer_run),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* src/uart_rx_shift.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_rx_shift (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     rx,
  input  wire logic                     mid_tick,
  output logic                          timer_run,
  output logic                          read_rdy,
  output logic [uart_pkg::READ_WIDTH:0] read_data
);

  localparam int unsigned CNT_W = $clog2(`UART_FRAME_BITS);

  localparam logic [CNT_W-1:0] STOP_IDX = CNT_W'(`UART_FRAME_BITS - 1);

  logic                          rx_meta;
  logic                          rx_sync;
  logic                          rx_prev;
  logic                          fall;
  logic [CNT_W-1:0]              bit_cnt;
  logic                          shift_en;
  logic [uart_pkg::READ_WIDTH:0] shift_q;
  logic                          frame_err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // data and parity shift in on mid-bit samples, between start and stop.
  assign shift_en = timer_run && mid_tick && (bit_cnt != '0) && (bit_cnt != STOP_IDX);

  // parity over data plus parity bit must be odd; stop must be high.
  assign frame_err = ~(^shift_q) | ~rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_run <= 1'b0;
      bit_cnt   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      if (!timer_run) begin
        bit_cnt <= '0;
        if (fall) begin
          timer_run <= 1'b1;
        end
      end else if (mid_tick) begin
        if (bit_cnt == '0) begin
          if (rx_sync) begin
            // start bit gone by mid-bit, treat as a glitch.
            timer_run <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else if (bit_cnt == STOP_IDX) begin
          timer_run <= 1'b0;
          read_rdy  <= 1'b1;
          read_data <= {frame_err, shift_q[uart_pkg::READ_WIDTH-1:0]};
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // lsb first, so new bits enter at the top.
  always_ff @(posedge clk) begin
    if (shift_en) begin
      shift_q <= {rx_sync, shift_q[uart_pkg::READ_WIDTH:1]};
    end
  end

endmodule

`default_nettype wire

/* src/uart_tx_shift.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_tx_shift (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       frame_start,
  input  wire logic [7:0] frame_byte,
  input  wire logic       bit_tick,
  output logic            timer_run,
  output logic            frame_done,
  output logic            tx
);

  localparam int unsigned CNT_W = $clog2(`UART_FRAME_BITS);

  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`UART_FRAME_BITS - 1);

  logic [`UART_FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]            bit_cnt;
  logic                        parity;

  // odd parity over the data byte.
  assign parity = ~^frame_byte;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q   <= '1;
      bit_cnt   <= '0;
      timer_run <= 1'b0;
    end else if (frame_start && !timer_run) begin
      shift_q   <= {1'b1, parity, frame_byte, 1'b0};
      bit_cnt   <= '0;
      timer_run <= 1'b1;
    end else if (timer_run && bit_tick) begin
      // ones fill in behind, so the line idles high.
      shift_q <= {1'b1, shift_q[`UART_FRAME_BITS-1:1]};
      if (bit_cnt == LAST_IDX) begin
        bit_cnt   <= '0;
        timer_run <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign tx = shift_q[0];

  // last cycle of the stop bit.
  assign frame_done = timer_run && bit_tick && (bit_cnt == LAST_IDX);

endmodule

`default_nettype wire

/* src/baud_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module baud_timer (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic timer_run,
  output logic      bit_tick,
  output logic      mid_tick
);

  localparam int unsigned CLKS  = `UART_CLKS_PER_BIT;
  localparam int unsigned CNT_W = (CLKS > 1) ? $clog2(CLKS) : 1;

  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS - 1);
  localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(CLKS / 2);

  logic [CNT_W-1:0] cnt;

  // idle keeps the count at zero so each frame starts in phase.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!timer_run) begin
      cnt <= '0;
    end else if (cnt == LAST_CNT) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick = timer_run && (cnt == LAST_CNT);
  assign mid_tick = timer_run && (cnt == MID_CNT);

endmodule

`default_nettype wire

/* src/uart_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_ctrl (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic [`UART_CMD_WIDTH-1:0] cmd_in,
  input  wire logic                       cmd_vld,
  input  wire logic                       frame_done,
  output logic                            cmd_rdy,
  output logic                            frame_start,
  output logic [7:0]                      frame_byte
);

  localparam logic [2:0] IDLE    = 3'd0;
  localparam logic [2:0] SEND_HI = 3'd1;
  localparam logic [2:0] WAIT_HI = 3'd2;
  localparam logic [2:0] SEND_LO = 3'd3;
  localparam logic [2:0] WAIT_LO = 3'd4;

  logic [2:0]          state;
  logic [2:0]          state_nxt;
  logic                accept;
  uart_pkg::cmd_word_t cmd_q;

  assign cmd_rdy = (state == IDLE);
  assign accept  = cmd_vld && cmd_rdy;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_nxt = SEND_HI;
        end
      end
      SEND_HI: state_nxt = WAIT_HI;
      WAIT_HI: begin
        if (frame_done) begin
          state_nxt = SEND_LO;
        end
      end
      SEND_LO: state_nxt = WAIT_LO;
      WAIT_LO: begin
        if (frame_done) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      frame_start <= 1'b0;
    end else begin
      state       <= state_nxt;
      // one pulse per frame, a cycle after the send state.
      frame_start <= (state == SEND_HI) || (state == SEND_LO);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q.raw <= cmd_in;
    end
  end

  // high byte goes out first.
  assign frame_byte = ((state == SEND_LO) || (state == WAIT_LO)) ?
                      cmd_q.bytes.lo : cmd_q.bytes.hi;

endmodule

`default_nettype wire

/* src/uart_pkg.sv */
`default_nettype none

`include "uart_settings.svh"

package uart_pkg;

  // command word, seen whole or as the two bytes that go on the line.
  typedef union packed {
    logic [`UART_CMD_WIDTH-1:0] raw;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } cmd_word_t;

  // data bits in one read result, the error flag sits just above them.
  localparam int unsigned READ_WIDTH = 8;

endpackage

`default_nettype wire

/* src/uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// clock cycles per serial bit.
// kept small so a whole frame stays short in simulation.
`define UART_CLKS_PER_BIT 8

// command word width, sent as two bytes.
`define UART_CMD_WIDTH 16

// start, eight data bits, odd parity, stop.
`define UART_FRAME_BITS 11

`endif
